//--- game_overlay.f
design/vga_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/pixel_delay.sv
design/score_text_rom.sv
design/font_rom.sv
design/score_overlay.sv
design/game_overlay_top.sv
test/game_overlay_checker.sv
test/game_overlay_tb.sv

//--- test/game_overlay_tb.sv
`timescale 1ns/1ps

module game_overlay_tb;

    import vga_pkg::*;
    import game_pkg::*;

    localparam int H_ACT = 120;
    localparam int H_TOT = 140;
    localparam int V_ACT = 40;
    localparam int V_TOT = 50;
    localparam int H_SS  = 124;                   // sync windows
    localparam int H_SL  = 8;
    localparam int V_SS  = 42;
    localparam int V_SL  = 2;
    localparam int TX    = 16;
    localparam int TY    = 8;
    localparam int FRAME = H_TOT * V_TOT;
    localparam int LIMIT = FRAME + 16;            // cycles before a wait gives up

    logic               clk;
    logic               rst;
    g_state             game_state;
    logic [SCORE_W-1:0] score_player;
    logic [SCORE_W-1:0] score_enemy;
    logic [COUNT_W-1:0] hcount;
    logic [COUNT_W-1:0] vcount;
    logic               hsync;
    logic               vsync;
    logic               hblnk;
    logic               vblnk;
    rgb_t               rgb;

    rgb_t frame_rgb [FRAME];                      // last captured frame
    int   errors;
    int   tests_run;
    int   tests_failed;

    game_overlay_top #(
        .H_ACTIVE     (H_ACT),
        .H_TOTAL      (H_TOT),
        .H_SYNC_START (H_SS),
        .H_SYNC_LEN   (H_SL),
        .V_ACTIVE     (V_ACT),
        .V_TOTAL      (V_TOT),
        .V_SYNC_START (V_SS),
        .V_SYNC_LEN   (V_SL),
        .TEXT_X       (TX),
        .TEXT_Y       (TY)
    ) DUT (
        .clk,
        .rst,
        .game_state,
        .score_player,
        .score_enemy,
        .hcount,
        .vcount,
        .hsync,
        .vsync,
        .hblnk,
        .vblnk,
        .rgb
    );

    always #20 clk = ~clk;

    task automatic compare_rgb(input rgb_t got, input rgb_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                                 input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compare_total(input int got, input int exp, input string what);
        if (got != exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors != errors_at_start) begin
            tests_failed++;
        end
        $display("%-18s %s", name, (errors == errors_at_start) ? "ok" : "mismatch");
    endtask

    // polls the outputs on falling edges until the given pixel shows up
    task automatic wait_pixel(input logic [COUNT_W-1:0] h, input logic [COUNT_W-1:0] v);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(hcount == h && vcount == v) && n < LIMIT);
        if (n >= LIMIT) begin
            $display("timed out waiting for pixel %0d,%0d at the output", h, v);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic capture_frame();
        wait_pixel('0, '0);
        for (int i = 0; i < FRAME; i++) begin
            if (i > 0) begin
                @(negedge clk);
            end
            compare_count(hcount, COUNT_W'(i % H_TOT), "hcount");
            compare_count(vcount, COUNT_W'(i / H_TOT), "vcount");
            frame_rgb[i] = rgb;
        end
    endtask

    // text pixels are only allowed inside the 56x16 window
    task automatic check_frame(input bit play, output int n_txt);
        int  h;
        int  v;
        bit  in_win;
        n_txt = 0;
        for (int i = 0; i < FRAME; i++) begin
            h      = i % H_TOT;
            v      = i / H_TOT;
            in_win = play && h >= TX && h < TX + GLYPH_W * TEXT_LEN && v >= TY && v < TY + GLYPH_H;
            if (in_win && frame_rgb[i] == TXT_COLOUR) begin
                n_txt++;
            end else if (h >= H_ACT || v >= V_ACT) begin
                compare_rgb(frame_rgb[i], rgb_t'(0), "blanked pixel");
            end else begin
                compare_rgb(frame_rgb[i], BG_COLOUR, "background pixel");
            end
        end
    endtask

    task automatic count_text(input logic [SCORE_W-1:0] a, input logic [SCORE_W-1:0] b,
                              output int n_txt);
        @(posedge clk);
        game_state   <= PLAY;
        score_player <= a;
        score_enemy  <= b;
        capture_frame();
        check_frame(1'b1, n_txt);
    endtask

    task automatic reset_count_test();
        int                 err0;
        logic [COUNT_W-1:0] h;
        logic [COUNT_W-1:0] v;
        err0 = errors;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < 6; i++) begin        // pipeline fill
            @(negedge clk);
            compare_rgb(rgb, rgb_t'(0), "rgb during fill");
            compare_count(hcount, '0, "hcount during fill");
            compare_count(vcount, '0, "vcount during fill");
            compare_flag(hsync | vsync, 1'b0, "sync during fill");
            compare_flag(hblnk | vblnk, 1'b0, "blank during fill");
        end
        h = '0;
        v = '0;
        for (int i = 0; i < FRAME + H_TOT; i++) begin
            @(negedge clk);
            if (i == 0) begin
                compare_rgb(rgb, BG_COLOUR, "first pixel");
            end
            compare_count(hcount, h, "hcount");
            compare_count(vcount, v, "vcount");
            compare_flag(hsync, h >= H_SS && h < H_SS + H_SL, "hsync");
            compare_flag(vsync, v >= V_SS && v < V_SS + V_SL, "vsync");
            compare_flag(hblnk, h >= H_ACT, "hblnk");
            compare_flag(vblnk, v >= V_ACT, "vblnk");
            if (h == H_TOT - 1) begin
                h = '0;
                v = (v == V_TOT - 1) ? '0 : v + 1'b1;
            end else begin
                h = h + 1'b1;
            end
        end
        finish_test("reset_and_count", err0);
    endtask

    task automatic bypass_test();
        int     err0;
        int     n;
        g_state states [3];
        err0      = errors;
        states[0] = START;
        states[1] = WINNER;
        states[2] = LOSER;
        foreach (states[k]) begin
            @(posedge clk);
            game_state   <= states[k];
            score_player <= 3'd2;
            score_enemy  <= 3'd6;
            capture_frame();
            check_frame(1'b0, n);
        end
        finish_test("bypass_states", err0);
    endtask

    task automatic play_text_test();
        int err0;
        int n;
        err0 = errors;
        count_text(3'd3, 3'd5, n);
        if (n == 0) begin
            errors++;
            $display("error at %0t: no text pixels drawn in PLAY", $time);
        end
        finish_test("play_text", err0);
    endtask

    task automatic score_symmetry_test();
        int                 err0;
        int                 n_ab;
        int                 n_ba;
        logic [SCORE_W-1:0] a;
        logic [SCORE_W-1:0] b;
        err0 = errors;
        for (int k = 0; k < 2; k++) begin
            a = SCORE_W'($urandom_range(7, 0));
            b = SCORE_W'($urandom_range(7, 0));
            count_text(a, b, n_ab);
            count_text(b, a, n_ba);
            compare_total(n_ba, n_ab, "text pixels with swapped scores");
        end
        count_text(3'd0, 3'd0, n_ab);
        count_text(3'd1, 3'd1, n_ba);
        if (n_ab == n_ba) begin
            errors++;
            $display("error at %0t: scores 0:0 and 1:1 give the same text pixel count %0d",
                     $time, n_ab);
        end
        finish_test("score_symmetry", err0);
    endtask

    task automatic state_change_test();
        int err0;
        int n;
        err0 = errors;
        @(posedge clk);
        game_state <= PLAY;
        wait_pixel('0, COUNT_W'(TY + 4));         // middle of the text rows
        @(posedge clk);
        game_state <= WINNER;
        capture_frame();
        check_frame(1'b0, n);
        finish_test("play_to_winner", err0);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        game_state   = START;
        score_player = '0;
        score_enemy  = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'h0504703c));

        reset_count_test();
        bypass_test();
        play_text_test();
        score_symmetry_test();
        state_change_test();

        compare_total(DUT.u_checker.assert_failures, 0, "assertion failures");
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- test/game_overlay_checker.sv
`timescale 1ns/1ps

module game_overlay_checker #(
    parameter int unsigned H_ACTIVE = vga_pkg::H_ACTIVE_DEF,
    parameter int unsigned H_TOTAL  = vga_pkg::H_TOTAL_DEF
) (
    input logic                        clk,
    input logic                        rst,
    input logic [vga_pkg::COUNT_W-1:0] hcount,
    input logic                        hblnk,
    input logic                        vblnk,
    input vga_pkg::rgb_t               rgb
);

    int assert_failures = 0;                      // failed assertion count

    hcount_range: assert property (@(posedge clk) disable iff (rst) hcount < H_TOTAL)
        else begin
            assert_failures++;
            $error("hcount %0d reached the line total", hcount);
        end

    hblnk_match: assert property (@(posedge clk) disable iff (rst)
        hblnk == (hcount >= H_ACTIVE))
        else begin
            assert_failures++;
            $error("hblnk %b does not match hcount %0d", hblnk, hcount);
        end

    // nothing may be painted in the blanking area
    blank_black: assert property (@(posedge clk) disable iff (rst)
        (hblnk || vblnk) |-> (rgb == '0))
        else begin
            assert_failures++;
            $error("rgb %h during blanking", rgb);
        end

endmodule

bind game_overlay_top game_overlay_checker #(
    .H_ACTIVE (H_ACTIVE),
    .H_TOTAL  (H_TOTAL)
) u_checker (
    .clk,
    .rst,
    .hcount,
    .hblnk,
    .vblnk,
    .rgb
);

//--- design/game_overlay_top.sv
`timescale 1ns/1ps

module game_overlay_top #(
    parameter int unsigned H_ACTIVE     = vga_pkg::H_ACTIVE_DEF,
    parameter int unsigned H_TOTAL      = vga_pkg::H_TOTAL_DEF,
    parameter int unsigned H_SYNC_START = vga_pkg::H_SYNC_START_DEF,
    parameter int unsigned H_SYNC_LEN   = vga_pkg::H_SYNC_LEN_DEF,
    parameter int unsigned V_ACTIVE     = vga_pkg::V_ACTIVE_DEF,
    parameter int unsigned V_TOTAL      = vga_pkg::V_TOTAL_DEF,
    parameter int unsigned V_SYNC_START = vga_pkg::V_SYNC_START_DEF,
    parameter int unsigned V_SYNC_LEN   = vga_pkg::V_SYNC_LEN_DEF,
    parameter int unsigned TEXT_X       = game_pkg::TEXT_X_DEF,
    parameter int unsigned TEXT_Y       = game_pkg::TEXT_Y_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  game_pkg::g_state             game_state,
    input  logic [game_pkg::SCORE_W-1:0] score_player,
    input  logic [game_pkg::SCORE_W-1:0] score_enemy,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output vga_pkg::rgb_t                rgb
);

    import vga_pkg::*;

    // raw raster from the generator
    logic [COUNT_W-1:0] tim_hcount;
    logic [COUNT_W-1:0] tim_vcount;
    logic               tim_hsync;
    logic               tim_vsync;
    logic               tim_hblnk;
    logic               tim_vblnk;
    rgb_t               tim_rgb;

    vga_timing #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC_START (H_SYNC_START),
        .H_SYNC_LEN   (H_SYNC_LEN),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC_START (V_SYNC_START),
        .V_SYNC_LEN   (V_SYNC_LEN)
    ) u_vga_timing (
        .clk,
        .rst,
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk),
        .rgb    (tim_rgb)
    );

    score_overlay #(
        .TEXT_X (TEXT_X),
        .TEXT_Y (TEXT_Y)
    ) u_score_overlay (
        .clk,
        .rst,
        .game_state,
        .score_player,
        .score_enemy,
        .hcount_in  (tim_hcount),
        .vcount_in  (tim_vcount),
        .hsync_in   (tim_hsync),
        .vsync_in   (tim_vsync),
        .hblnk_in   (tim_hblnk),
        .vblnk_in   (tim_vblnk),
        .rgb_in     (tim_rgb),
        .hcount_out (hcount),
        .vcount_out (vcount),
        .hsync_out  (hsync),
        .vsync_out  (vsync),
        .hblnk_out  (hblnk),
        .vblnk_out  (vblnk),
        .rgb_out    (rgb)
    );

endmodule

//--- design/score_overlay.sv
`timescale 1ns/1ps

module score_overlay #(
    parameter int unsigned TEXT_X = game_pkg::TEXT_X_DEF,
    parameter int unsigned TEXT_Y = game_pkg::TEXT_Y_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    input  game_pkg::g_state             game_state,
    input  logic [game_pkg::SCORE_W-1:0] score_player,
    input  logic [game_pkg::SCORE_W-1:0] score_enemy,
    input  logic [vga_pkg::COUNT_W-1:0]  hcount_in,
    input  logic [vga_pkg::COUNT_W-1:0]  vcount_in,
    input  logic                         hsync_in,
    input  logic                         vsync_in,
    input  logic                         hblnk_in,
    input  logic                         vblnk_in,
    input  vga_pkg::rgb_t                rgb_in,
    output logic [vga_pkg::COUNT_W-1:0]  hcount_out,
    output logic [vga_pkg::COUNT_W-1:0]  vcount_out,
    output logic                         hsync_out,
    output logic                         vsync_out,
    output logic                         hblnk_out,
    output logic                         vblnk_out,
    output vga_pkg::rgb_t                rgb_out
);

    import vga_pkg::*;
    import game_pkg::*;

    localparam int          LOOKUP_DELAY = 4;    // index reg, text rom, addr reg, font rom
    localparam int unsigned TEXT_W       = GLYPH_W * TEXT_LEN;

    logic [COUNT_W-1:0]  rel_x;
    logic [COUNT_W-1:0]  rel_y;
    logic                in_window;
    logic [2:0]          char_index_r;
    logic [3:0]          line_r1;
    logic [3:0]          line_r2;
    char_code_t          char_code;
    font_addr_u          font_addr_r;
    logic [7:0]          line_pixels;
    logic [3:0]          side_d;
    logic                win_d;
    logic [2:0]          col_d;
    logic [RASTER_W-1:0] raster_d;
    logic [COUNT_W-1:0]  hcount_d;
    logic [COUNT_W-1:0]  vcount_d;
    logic                hsync_d;
    logic                vsync_d;
    logic                hblnk_d;
    logic                vblnk_d;
    rgb_t                rgb_d;
    rgb_t                rgb_nxt;

    assign rel_x     = COUNT_W'(hcount_in - TEXT_X);
    assign rel_y     = COUNT_W'(vcount_in - TEXT_Y);
    assign in_window = (hcount_in >= TEXT_X) && (rel_x < TEXT_W)
                    && (vcount_in >= TEXT_Y) && (rel_y < GLYPH_H)
                    && !hblnk_in && !vblnk_in;

    always_ff @(posedge clk) begin
        char_index_r <= rel_x[5:3];               // one cell per 8 pixels
        line_r1      <= rel_y[3:0];
        line_r2      <= line_r1;                  // matches text rom latency
        font_addr_r.fields.char_code <= char_code;
        font_addr_r.fields.line      <= line_r2;
    end

    score_text_rom u_score_text_rom (
        .clk,
        .char_index   (char_index_r),
        .score_player,
        .score_enemy,
        .char_code
    );

    font_rom u_font_rom (
        .clk,
        .addr        (font_addr_r),
        .line_pixels
    );

    // window flag and column travel with the lookup
    pixel_delay #(.DELAY(LOOKUP_DELAY), .WIDTH(4)) u_side_delay (
        .clk,
        .rst,
        .din  ({in_window, rel_x[2:0]}),
        .dout (side_d)
    );

    pixel_delay #(.DELAY(LOOKUP_DELAY), .WIDTH(RASTER_W)) u_raster_delay (
        .clk,
        .rst,
        .din  ({hcount_in, vcount_in, hsync_in, vsync_in, hblnk_in, vblnk_in, rgb_in}),
        .dout (raster_d)
    );

    assign {win_d, col_d} = side_d;
    assign {hcount_d, vcount_d, hsync_d, vsync_d, hblnk_d, vblnk_d, rgb_d} = raster_d;

    always_comb begin
        rgb_nxt = rgb_d;                          // bypass in non-play states
        if (game_state == PLAY && win_d && line_pixels[3'd7 - col_d]) begin
            rgb_nxt = TXT_COLOUR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= '0;
        end else begin
            hcount_out <= hcount_d;
            vcount_out <= vcount_d;
            hsync_out  <= hsync_d;
            vsync_out  <= vsync_d;
            hblnk_out  <= hblnk_d;
            vblnk_out  <= vblnk_d;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

//--- design/font_rom.sv
`timescale 1ns/1ps

module font_rom (
    input  logic                clk,
    input  vga_pkg::font_addr_u addr,
    output logic [7:0]          line_pixels
);

    import vga_pkg::*;

    logic [GLYPH_W*GLYPH_H-1:0] glyph;            // row 0 in the top byte
    logic [3:0]                 row;
    logic [GLYPH_W-1:0]         row_pixels;

    // upper 7 bits of the flat index select the glyph
    always_comb begin
        case (addr.index[10:4])
            7'h30:   glyph = 128'h00007CC6C6CEDEF6E6C6C67C00000000;  // 0
            7'h31:   glyph = 128'h0000183878181818181818_7E00000000;  // 1
            7'h32:   glyph = 128'h00007CC6060C183060C0C6FE00000000;  // 2
            7'h33:   glyph = 128'h00007CC606063C060606C67C00000000;  // 3
            7'h34:   glyph = 128'h00000C1C3C6CCCFE0C0C0C1E00000000;  // 4
            7'h35:   glyph = 128'h0000FEC0C0C0FC060606C67C00000000;  // 5
            7'h36:   glyph = 128'h00003860C0C0FCC6C6C6C67C00000000;  // 6
            7'h37:   glyph = 128'h0000FEC606060C183030303000000000;  // 7
            7'h50:   glyph = 128'h0000FC6666667C60606060F000000000;  // P
            7'h45:   glyph = 128'h0000FE66626878686062_66FE00000000;  // E
            7'h3A:   glyph = 128'h00000000181800000018180000000000;  // colon
            default: glyph = '0;                  // space and all unsupported codes
        endcase
    end

    assign row        = addr.index[3:0];
    assign row_pixels = glyph[(GLYPH_H - 1 - int'(row)) * GLYPH_W +: GLYPH_W];

    always_ff @(posedge clk) begin
        line_pixels <= row_pixels;                // msb is the leftmost pixel
    end

endmodule

//--- design/score_text_rom.sv
`timescale 1ns/1ps

module score_text_rom (
    input  logic                         clk,
    input  logic [2:0]                   char_index,
    input  logic [game_pkg::SCORE_W-1:0] score_player,
    input  logic [game_pkg::SCORE_W-1:0] score_enemy,
    output game_pkg::char_code_t         char_code
);

    import game_pkg::*;

    char_code_t player_digit;
    char_code_t enemy_digit;

    // ascii digit from a 3-bit score
    assign player_digit = CHAR_ZERO + char_code_t'(score_player);
    assign enemy_digit  = CHAR_ZERO + char_code_t'(score_enemy);

    always_ff @(posedge clk) begin
        case (char_index)
            3'd0:    char_code <= CHAR_P;
            3'd1:    char_code <= CHAR_COLON;
            3'd2:    char_code <= player_digit;
            3'd3:    char_code <= CHAR_SPACE;
            3'd4:    char_code <= CHAR_E;
            3'd5:    char_code <= CHAR_COLON;
            3'd6:    char_code <= enemy_digit;
            default: char_code <= CHAR_SPACE;     // index 7 lies past the line
        endcase
    end

endmodule

//--- design/pixel_delay.sv
`timescale 1ns/1ps

module pixel_delay #(
    parameter int DELAY = 4,                      // number of stages, at least 1
    parameter int WIDTH = 38
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [DELAY];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DELAY; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < DELAY; i++) begin
                stage[i] <= stage[i-1];           // shift one stage per clock
            end
        end
    end

    assign dout = stage[DELAY-1];

endmodule

//--- design/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int unsigned H_ACTIVE     = vga_pkg::H_ACTIVE_DEF,
    parameter int unsigned H_TOTAL      = vga_pkg::H_TOTAL_DEF,
    parameter int unsigned H_SYNC_START = vga_pkg::H_SYNC_START_DEF,
    parameter int unsigned H_SYNC_LEN   = vga_pkg::H_SYNC_LEN_DEF,
    parameter int unsigned V_ACTIVE     = vga_pkg::V_ACTIVE_DEF,
    parameter int unsigned V_TOTAL      = vga_pkg::V_TOTAL_DEF,
    parameter int unsigned V_SYNC_START = vga_pkg::V_SYNC_START_DEF,
    parameter int unsigned V_SYNC_LEN   = vga_pkg::V_SYNC_LEN_DEF
) (
    input  logic                         clk,
    input  logic                         rst,
    output logic [vga_pkg::COUNT_W-1:0]  hcount,
    output logic [vga_pkg::COUNT_W-1:0]  vcount,
    output logic                         hsync,
    output logic                         vsync,
    output logic                         hblnk,
    output logic                         vblnk,
    output vga_pkg::rgb_t                rgb
);

    import vga_pkg::*;

    logic [COUNT_W-1:0] h_cnt;                    // next pixel to emit
    logic [COUNT_W-1:0] v_cnt;
    logic               h_last;
    logic               v_last;
    logic               h_blank;
    logic               v_blank;

    assign h_last  = (h_cnt == H_TOTAL - 1);
    assign v_last  = (v_cnt == V_TOTAL - 1);
    assign h_blank = (h_cnt >= H_ACTIVE);
    assign v_blank = (v_cnt >= V_ACTIVE);

    always_ff @(posedge clk) begin
        if (rst) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;  // new line, maybe new frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= h_cnt;
            vcount <= v_cnt;
            hsync  <= (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_START + H_SYNC_LEN);
            vsync  <= (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_START + V_SYNC_LEN);
            hblnk  <= h_blank;
            vblnk  <= v_blank;
            rgb    <= (h_blank || v_blank) ? rgb_t'(0) : BG_COLOUR;  // black in blanking
        end
    end

endmodule

//--- design/game_pkg.sv
package game_pkg;

    typedef enum logic [1:0] {
        START  = 2'd0,
        PLAY   = 2'd1,
        WINNER = 2'd2,
        LOSER  = 2'd3
    } g_state;

    localparam int SCORE_W  = 3;
    localparam int TEXT_LEN = 7;                  // "P:n E:m"

    typedef logic [6:0] char_code_t;              // 7-bit ascii

    localparam char_code_t CHAR_P     = 7'h50;
    localparam char_code_t CHAR_E     = 7'h45;
    localparam char_code_t CHAR_COLON = 7'h3A;
    localparam char_code_t CHAR_SPACE = 7'h20;
    localparam char_code_t CHAR_ZERO  = 7'h30;    // digits count up from here

    // default score line origin, top right of an 800x600 screen
    localparam int unsigned TEXT_X_DEF = 720;
    localparam int unsigned TEXT_Y_DEF = 20;

endpackage

//--- design/vga_pkg.sv
package vga_pkg;

    localparam int COUNT_W = 11;                  // hcount / vcount width

    typedef logic [11:0] rgb_t;                   // 4 bits per channel

    localparam int RASTER_W = 2 * COUNT_W + 4 + $bits(rgb_t);  // counters, syncs, blanks, rgb

    localparam rgb_t BG_COLOUR  = 12'h4_6_8;
    localparam rgb_t TXT_COLOUR = 12'hF_0_0;      // red

    // 800x600 raster
    localparam int unsigned H_ACTIVE_DEF     = 800;
    localparam int unsigned H_TOTAL_DEF      = 1056;
    localparam int unsigned H_SYNC_START_DEF = 840;
    localparam int unsigned H_SYNC_LEN_DEF   = 128;
    localparam int unsigned V_ACTIVE_DEF     = 600;
    localparam int unsigned V_TOTAL_DEF      = 628;
    localparam int unsigned V_SYNC_START_DEF = 601;
    localparam int unsigned V_SYNC_LEN_DEF   = 4;

    localparam int GLYPH_W = 8;
    localparam int GLYPH_H = 16;

    // font memory index, built from fields and read as one word
    typedef union packed {
        logic [10:0] index;
        struct packed {
            logic [6:0] char_code;
            logic [3:0] line;                     // glyph row
        } fields;
    } font_addr_u;

endpackage
